//--- sim.f
+incdir+src
src/cnn_pkg.sv
src/weight_dma.sv
src/conv_relu_stage.sv
src/max_pool_stage.sv
src/fc_argmax_stage.sv
src/cnn_core_top.sv
verification/tb_cnn_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cnn core testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cnn_core -f sim.f -o tb_cnn_core
./obj_dir/tb_cnn_core | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
  echo "run_sim: simulation passed"
else
  echo "run_sim: simulation failed"
  exit 1
fi

//--- verification/tb_cnn_core.sv
`include "cnn_config.svh"

module tb_cnn_core import cnn_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LOAD_CYCLES = 27;   // start cycle to loaded level
  localparam int RESULT_LAT  = 4;    // 16th sample edge to result edge
  localparam int TIMEOUT     = 300;  // cycles per wait loop

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   i_start;
  wgt_word_u              i_sram_data;
  pix_beat_t              i_pix;
  logic [`CNN_ADDR_W-1:0] o_sram_addr;
  logic                   o_sram_rd;
  logic                   o_wgt_loaded;
  result_t                o_result;

  logic [`CNN_WGT_W-1:0]  sram_mem [`CNN_WGT_WORDS];  // external weight sram
  logic [`CNN_ADDR_W-1:0] rd_addr_q = '0;             // address of last read
  logic [`CNN_PIX_W-1:0]  frame [`CNN_FRAME_LEN];     // frame being sent
  int unsigned            cyc = 0;                    // posedge count
  int                     rd_cnt = 0;                 // reads in current burst
  logic                   rd_prev = 1'b0;
  int                     exp_class_q [$];            // per sent frame
  int unsigned            exp_time_q [$];             // cycle the result is due

  cnn_core_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_start      (i_start),
    .i_sram_data  (i_sram_data),
    .i_pix        (i_pix),
    .o_sram_addr  (o_sram_addr),
    .o_sram_rd    (o_sram_rd),
    .o_wgt_loaded (o_wgt_loaded),
    .o_result     (o_result)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_mismatch(input string name, input int exp, input int act);
    $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    abort_run();
  endtask

  // sram model, one cycle read latency, data driven on the falling edge
  always @(posedge clk) begin
    if (o_sram_rd) rd_addr_q <= o_sram_addr;
  end

  always @(negedge clk) begin
    i_sram_data <= sram_mem[rd_addr_q];
  end

  // read burst must be 0..24 in order with no gap
  always @(posedge clk) begin
    if (rst_n) begin
      if (o_sram_rd) begin
        a_rd_order: assert (int'(o_sram_addr) == rd_cnt)
          else report_mismatch("o_sram_addr", rd_cnt, o_sram_addr);
        rd_cnt = rd_cnt + 1;
      end else if (rd_prev) begin
        a_rd_burst: assert (rd_cnt == `CNN_WGT_WORDS)
          else report_mismatch("sram read count", `CNN_WGT_WORDS, rd_cnt);
        rd_cnt = 0;  // burst closed
      end
      rd_prev = o_sram_rd;
    end
  end

  // each result is matched against the oldest frame sent
  always @(posedge clk) begin
    int          exp_c;
    int unsigned exp_t;
    if (rst_n && o_result.valid) begin
      if (exp_class_q.size() == 0) begin
        report_error("result valid with no frame outstanding");
      end else begin
        exp_c = exp_class_q.pop_front();
        exp_t = exp_time_q.pop_front();
        a_class: assert (int'(o_result.class_idx) == exp_c)
          else report_mismatch("o_result.class_idx", exp_c, o_result.class_idx);
        a_latency: assert (cyc == exp_t)
          else report_mismatch("o_result.valid cycle", exp_t, cyc);
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (!o_sram_rd && !o_wgt_loaded && !o_result.valid))
    else report_error("outputs active while reset is asserted");

  a_loaded_drop: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(o_wgt_loaded) |-> $past(i_start))
    else report_error("o_wgt_loaded dropped without a start pulse");

  // reference model, taps and fc weights decoded straight from the sram image
  function automatic int expected_class();
    int     tap [`CNN_TAPS];
    int     feat [`CNN_FRAME_LEN - `CNN_TAPS + 1];
    int     pool [`CNN_POOL_LEN];
    longint score;
    longint best_score;
    int     best;
    for (int k = 0; k < `CNN_TAPS; k++) tap[k] = $signed(sram_mem[0][4*k +: 4]);
    for (int j = 0; j <= `CNN_FRAME_LEN - `CNN_TAPS; j++) begin
      feat[j] = 0;
      for (int k = 0; k < `CNN_TAPS; k++) begin
        feat[j] += tap[k] * int'(frame[j + `CNN_TAPS - 1 - k]);
      end
      if (feat[j] < 0) feat[j] = 0;  // relu
    end
    for (int i = 0; i < `CNN_POOL_LEN; i++) begin
      pool[i] = (feat[2*i+1] > feat[2*i]) ? feat[2*i+1] : feat[2*i];
    end
    best = 0;
    best_score = 0;
    for (int c = 0; c < `CNN_NUM_CLASS; c++) begin
      score = 0;
      for (int i = 0; i < `CNN_POOL_LEN; i++) begin
        score += longint'(pool[i]) * $signed(sram_mem[1 + c*`CNN_POOL_LEN + i]);
      end
      if (c == 0 || score > best_score) begin  // ties keep lower class
        best = c;
        best_score = score;
      end
    end
    return best;
  endfunction

  // called just after a falling edge, returns just after one
  task automatic send_frame(input int max_gap, input bit counted);
    int gap;
    if (counted) exp_class_q.push_back(expected_class());
    for (int n = 0; n < `CNN_FRAME_LEN; n++) begin
      gap = (n == 0 || n == `CNN_FRAME_LEN - 1) ? 0 : $urandom_range(max_gap);
      i_pix.valid = 1'b0;
      repeat (gap) @(negedge clk);
      i_pix.valid = 1'b1;
      i_pix.data  = frame[n];
      if (counted && n == `CNN_FRAME_LEN - 1) exp_time_q.push_back(cyc + RESULT_LAT);
      @(negedge clk);
    end
    i_pix.valid = 1'b0;
  endtask

  task automatic load_weights();
    int cnt;
    i_start = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    cnt = 1;
    a_loaded_low: assert (!o_wgt_loaded) else report_mismatch("o_wgt_loaded", 0, 1);
    while (!o_wgt_loaded && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!o_wgt_loaded) report_error("timeout waiting for o_wgt_loaded");
    a_load_time: assert (cnt == LOAD_CYCLES)
      else report_mismatch("o_wgt_loaded rise cycle", LOAD_CYCLES, cnt);
  endtask

  task automatic wait_drained();
    int cnt;
    cnt = 0;
    while (exp_class_q.size() != 0 && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (exp_class_q.size() != 0) report_error("timeout waiting for pending results");
  endtask

  task automatic fill_random_frame();
    for (int n = 0; n < `CNN_FRAME_LEN; n++) frame[n] = $urandom();
  endtask

  initial begin
    void'($urandom(78));
    rst_n   = 1'b0;
    i_start = 1'b0;
    i_pix   = '0;
    i_sram_data = '0;
    for (int a = 0; a < `CNN_WGT_WORDS; a++) sram_mem[a] = $urandom();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    a_idle: assert (!o_sram_rd && !o_wgt_loaded && !o_result.valid)
      else report_error("outputs not idle after reset");
    fill_random_frame();
    send_frame(0, 1'b0);  // no weights yet, must be dropped
    repeat (10) @(negedge clk);
    load_weights();
    for (int f = 0; f < 6; f++) begin  // back-to-back
      fill_random_frame();
      send_frame(0, 1'b1);
    end
    for (int f = 0; f < 8; f++) begin  // gaps inside and between frames
      fill_random_frame();
      send_frame(2, 1'b1);
      repeat ($urandom_range(3)) @(negedge clk);
    end
    wait_drained();
    // taps +1 -4 +1 -4, even classes -100, odd classes +50
    sram_mem[0] = 16'hC1C1;
    for (int a = 1; a < `CNN_WGT_WORDS; a++) begin
      sram_mem[a] = (((a - 1) / `CNN_POOL_LEN) % 2 == 0) ? 16'hFF9C : 16'h0032;
    end
    load_weights();
    for (int n = 0; n < `CNN_FRAME_LEN; n++) frame[n] = 8'd200;  // all sums negative
    send_frame(0, 1'b1);
    for (int n = 0; n < `CNN_FRAME_LEN; n++) frame[n] = n[0] ? 8'd0 : 8'd255;  // odd classes tie
    send_frame(0, 1'b1);
    for (int f = 0; f < 4; f++) begin
      fill_random_frame();
      send_frame(1, 1'b1);
    end
    wait_drained();
    repeat (10) @(negedge clk);  // no stray results
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- src/cnn_core_top.sv
`include "cnn_config.svh"

module cnn_core_top import cnn_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_start,       // weight load request
  input  wgt_word_u              i_sram_data,   // external weight sram
  input  pix_beat_t              i_pix,         // sample stream
  output logic [`CNN_ADDR_W-1:0] o_sram_addr,
  output logic                   o_sram_rd,
  output logic                   o_wgt_loaded,
  output result_t                o_result       // class per frame
);

  wgt_wr_t    wr_bus;     // dma writes, both stores listen
  feat_beat_t conv_feat;  // conv to pool
  feat_beat_t pool_feat;  // pool to fc

  // sram to local stores
  weight_dma u_dma (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_start      (i_start),
    .i_sram_data  (i_sram_data),
    .o_sram_addr  (o_sram_addr),
    .o_sram_rd    (o_sram_rd),
    .o_wr         (wr_bus),
    .o_wgt_loaded (o_wgt_loaded)
  );

  conv_relu_stage u_conv (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_wr         (wr_bus),
    .i_wgt_loaded (o_wgt_loaded),  // samples dropped until loaded
    .i_pix        (i_pix),
    .o_feat       (conv_feat)
  );

  max_pool_stage u_pool (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_feat (conv_feat),
    .o_feat (pool_feat)
  );

  // fc weights and class decision
  fc_argmax_stage u_fc (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_wr     (wr_bus),
    .i_feat   (pool_feat),
    .o_result (o_result)
  );

endmodule

//--- src/fc_argmax_stage.sv
`include "cnn_config.svh"

module fc_argmax_stage import cnn_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  wgt_wr_t    i_wr,      // dma writes, words 1..24 used here
  input  feat_beat_t i_feat,    // pooled features
  output result_t    o_result
);

  localparam int POS_W = $clog2(`CNN_POOL_LEN);
  localparam int CLS_W = $clog2(`CNN_NUM_CLASS);

  logic signed [`CNN_WGT_W-1:0] wgt_q [`CNN_NUM_CLASS][`CNN_POOL_LEN];  // class-major
  logic signed [`CNN_ACC_W-1:0] acc_q [`CNN_NUM_CLASS];  // running scores
  logic [POS_W-1:0]             pos_q;       // weight column
  logic                         done_q;      // scores final
  logic                         res_valid_q;
  logic [CLS_W-1:0]             res_class_q;
  logic [CLS_W-1:0]             best_idx;
  logic signed [`CNN_ACC_W-1:0] best_val;

  // weight store, word 1 + class*6 + position
  always_ff @(posedge clk) begin
    for (int c = 0; c < `CNN_NUM_CLASS; c++) begin
      for (int p = 0; p < `CNN_POOL_LEN; p++) begin
        if (i_wr.valid && (int'(i_wr.index) == 1 + c * `CNN_POOL_LEN + p)) begin
          wgt_q[c][p] <= i_wr.word.fc;  // 16-bit view of the word
        end
      end
    end
  end

  // multiply-accumulate, first feature of frame overwrites
  always_ff @(posedge clk) begin
    if (i_feat.valid) begin
      for (int c = 0; c < `CNN_NUM_CLASS; c++) begin
        if (pos_q == '0) begin
          acc_q[c] <= $signed({1'b0, i_feat.data}) * wgt_q[c][pos_q];
        end else begin
          acc_q[c] <= acc_q[c] + $signed({1'b0, i_feat.data}) * wgt_q[c][pos_q];
        end
      end
    end
  end

  // argmax, strict compare keeps the lowest index on ties
  always_comb begin
    best_idx = '0;
    best_val = acc_q[0];
    for (int c = 1; c < `CNN_NUM_CLASS; c++) begin
      if (acc_q[c] > best_val) begin
        best_idx = CLS_W'(c);
        best_val = acc_q[c];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos_q       <= '0;
      done_q      <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      done_q      <= i_feat.valid && i_feat.last;
      res_valid_q <= done_q;  // one pulse per frame
      if (i_feat.valid) begin
        pos_q <= i_feat.last ? '0 : pos_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done_q) begin
      res_class_q <= best_idx;  // compare runs the cycle after last
    end
  end

  assign o_result = '{valid: res_valid_q, class_idx: res_class_q};

  a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    o_result.valid |=> !o_result.valid)
    else $error("fc_argmax_stage: result valid held longer than one cycle");

endmodule

//--- src/max_pool_stage.sv
`include "cnn_config.svh"

module max_pool_stage import cnn_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  feat_beat_t i_feat,  // conv features, 13 per frame
  output feat_beat_t o_feat   // pooled features, 6 per frame
);

  localparam int POS_W = $clog2(2 * `CNN_POOL_LEN + 1);
  localparam logic [POS_W-1:0] LAST_PAIR = POS_W'(2 * `CNN_POOL_LEN - 1);

  logic [POS_W-1:0]       pos_q;      // input feature index in frame
  logic [`CNN_FEAT_W-1:0] held_q;     // first feature of pair
  logic                   emit;
  logic                   out_valid_q;
  logic                   out_last_q;
  logic [`CNN_FEAT_W-1:0] out_data_q;

  // odd index closes a pair; the lone 13th arrives on even index
  assign emit = i_feat.valid && pos_q[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos_q       <= '0;
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
    end else begin
      out_valid_q <= emit;
      out_last_q  <= emit && (pos_q == LAST_PAIR);  // 6th pooled output
      if (i_feat.valid) begin
        pos_q <= i_feat.last ? '0 : pos_q + 1'b1;  // realign on frame end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_feat.valid && !pos_q[0]) begin
      held_q <= i_feat.data;
    end
    if (emit) begin
      out_data_q <= (i_feat.data > held_q) ? i_feat.data : held_q;
    end
  end

  assign o_feat = '{valid: out_valid_q, last: out_last_q, data: out_data_q};

  a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
    o_feat.valid |=> !o_feat.valid)
    else $error("max_pool_stage: pooled outputs on consecutive cycles");

endmodule

//--- src/conv_relu_stage.sv
`include "cnn_config.svh"

module conv_relu_stage import cnn_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  wgt_wr_t    i_wr,          // dma write bus, only word 0 kept
  input  logic       i_wgt_loaded,  // gates sample acceptance
  input  pix_beat_t  i_pix,
  output feat_beat_t o_feat
);

  localparam int CNT_W = $clog2(`CNN_FRAME_LEN);
  localparam logic [CNT_W-1:0] FIRST_OUT = CNT_W'(`CNN_TAPS - 1);   // 4th sample
  localparam logic [CNT_W-1:0] LAST_SMP  = CNT_W'(`CNN_FRAME_LEN - 1);

  tap_t [`CNN_TAPS-1:0]                   taps_q;       // kernel from word 0
  logic [`CNN_TAPS-1:0][`CNN_PIX_W-1:0]   win_q;        // [0] newest sample
  logic [CNT_W-1:0]                       cnt_q;        // position in frame
  logic                                   accept;
  logic                                   fire_q;       // window full
  logic                                   fire_last_q;  // window ends frame
  logic                                   feat_valid_q;
  logic                                   feat_last_q;
  logic [`CNN_FEAT_W-1:0]                 feat_data_q;
  logic signed [`CNN_FEAT_W-1:0]          dot;          // signed tap sum

  assign accept = i_pix.valid && i_wgt_loaded;  // drop until weights valid

  // signed dot product over the registered window
  always_comb begin
    dot = '0;
    for (int k = 0; k < `CNN_TAPS; k++) begin
      dot = dot + $signed({1'b0, win_q[k]}) * taps_q[k];  // zero-extend sample
    end
  end

  always_ff @(posedge clk) begin
    if (i_wr.valid && (i_wr.index == '0)) begin
      taps_q <= i_wr.word.conv;  // nibble view of word 0
    end
    if (accept) begin
      win_q <= {win_q[`CNN_TAPS-2:0], i_pix.data};  // shift in newest
    end
    if (fire_q) begin
      feat_data_q <= dot[`CNN_FEAT_W-1] ? '0 : dot;  // relu clamp
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q        <= '0;
      fire_q       <= 1'b0;
      fire_last_q  <= 1'b0;
      feat_valid_q <= 1'b0;
      feat_last_q  <= 1'b0;
    end else begin
      fire_q       <= accept && (cnt_q >= FIRST_OUT);
      fire_last_q  <= accept && (cnt_q == LAST_SMP);
      feat_valid_q <= fire_q;
      feat_last_q  <= fire_last_q;  // 13th feature
      if (accept) begin
        cnt_q <= (cnt_q == LAST_SMP) ? '0 : cnt_q + 1'b1;
      end
    end
  end

  assign o_feat = '{valid: feat_valid_q, last: feat_last_q, data: feat_data_q};

  // weights still in place the cycle before a feature leaves
  a_feat_after_load: assert property (@(posedge clk) disable iff (!rst_n)
    o_feat.valid |-> $past(i_wgt_loaded))
    else $error("conv_relu_stage: feature emitted after weights were invalidated");

endmodule

//--- src/weight_dma.sv
`include "cnn_config.svh"

module weight_dma import cnn_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_start,       // one-cycle load request
  input  wgt_word_u              i_sram_data,   // one cycle after read
  output logic [`CNN_ADDR_W-1:0] o_sram_addr,
  output logic                   o_sram_rd,
  output wgt_wr_t                o_wr,          // broadcast to stages
  output logic                   o_wgt_loaded   // level, all words stored
);

  localparam int IDX_W = $clog2(`CNN_WGT_WORDS);
  localparam logic [`CNN_ADDR_W-1:0] LAST_ADDR = `CNN_ADDR_W'(`CNN_WGT_WORDS - 1);
  localparam logic [IDX_W-1:0]       LAST_IDX  = IDX_W'(`CNN_WGT_WORDS - 1);

  typedef enum logic {
    ST_IDLE,
    ST_READ
  } state_e;

  state_e                 state_q;
  logic [`CNN_ADDR_W-1:0] addr_q;      // read pointer
  logic                   wr_valid_q;  // read issued last cycle
  logic [IDX_W-1:0]       wr_idx_q;    // address of that read
  logic                   loaded_q;
  logic                   start_ok;

  // start only honoured between loads
  assign start_ok = i_start && ((state_q == ST_IDLE) || loaded_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      addr_q  <= '0;
    end else if (start_ok) begin
      state_q <= ST_READ;
      addr_q  <= '0;  // restart from word 0
    end else if (state_q == ST_READ) begin
      if (addr_q == LAST_ADDR) begin
        state_q <= ST_IDLE;  // 25th read issued
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_valid_q <= 1'b0;
      loaded_q   <= 1'b0;
    end else begin
      wr_valid_q <= (state_q == ST_READ);  // data returns next cycle
      if (start_ok) begin
        loaded_q <= 1'b0;  // reload invalidates stores
      end else if (wr_valid_q && (wr_idx_q == LAST_IDX)) begin
        loaded_q <= 1'b1;  // final write lands this edge
      end
    end
  end

  // index tag follows the read by one cycle
  always_ff @(posedge clk) begin
    wr_idx_q <= addr_q[IDX_W-1:0];
  end

  assign o_sram_addr  = addr_q;
  assign o_sram_rd    = (state_q == ST_READ);
  assign o_wgt_loaded = loaded_q;
  assign o_wr         = '{valid: wr_valid_q, index: wr_idx_q, word: i_sram_data};

  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    o_sram_rd |-> (o_sram_addr <= LAST_ADDR))
    else $error("weight_dma: read address past last weight word");

  a_no_wr_when_loaded: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_wr.valid && o_wgt_loaded))
    else $error("weight_dma: weight write while marked loaded");

endmodule

//--- src/cnn_pkg.sv
`include "cnn_config.svh"

package cnn_pkg;

  // one conv tap, four of them fill a weight word
  typedef logic signed [`CNN_WGT_W/`CNN_TAPS-1:0] tap_t;

  // sram word, either the tap nibbles or one fc weight
  typedef union packed {
    tap_t [`CNN_TAPS-1:0]          conv;  // tap 0 in low nibble
    logic signed [`CNN_WGT_W-1:0]  fc;    // class-major fc weight
  } wgt_word_u;

  // dma write broadcast to local weight stores
  typedef struct packed {
    logic                              valid;
    logic [$clog2(`CNN_WGT_WORDS)-1:0] index;  // sram word number
    wgt_word_u                         word;
  } wgt_wr_t;

  // input sample beat
  typedef struct packed {
    logic                  valid;
    logic [`CNN_PIX_W-1:0] data;
  } pix_beat_t;

  // feature beat between stages
  typedef struct packed {
    logic                   valid;
    logic                   last;  // final feature of frame
    logic [`CNN_FEAT_W-1:0] data;
  } feat_beat_t;

  // classification result
  typedef struct packed {
    logic                              valid;
    logic [$clog2(`CNN_NUM_CLASS)-1:0] class_idx;
  } result_t;

endpackage

//--- src/cnn_config.svh
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// frame geometry
`define CNN_FRAME_LEN  16  // samples per frame
`define CNN_TAPS       4   // conv kernel length
`define CNN_POOL_LEN   6   // pooled features per frame
`define CNN_NUM_CLASS  4   // classifier outputs

// weight image in external sram
`define CNN_WGT_WORDS  25  // word 0 taps, words 1..24 fc
`define CNN_WGT_W      16  // sram word width

// datapath widths
`define CNN_PIX_W      8   // unsigned sample
`define CNN_FEAT_W     16  // post-relu feature
`define CNN_ACC_W      32  // fc class score
`define CNN_ADDR_W     16  // sram address

`endif
